//--- hw/cpu_dp_macros.svh
`ifndef CPU_DP_MACROS_SVH
`define CPU_DP_MACROS_SVH

// Width of every internal bus and register
`define CPU_DP_DATA_W 8

// External address with ADH above ADL
`define CPU_DP_ADDR_W 16

// Undriven buses are precharged high
`define CPU_DP_IDLE_BUS {`CPU_DP_DATA_W{1'b1}}

`endif

//--- hw/cpu_dp_pkg.sv
`default_nettype none

`include "cpu_dp_macros.svh"

package cpu_dp_pkg;

    // One bus or register value
    typedef logic [`CPU_DP_DATA_W-1:0] byte_t;

    // External address as {ADH, ADL}
    typedef logic [`CPU_DP_ADDR_W-1:0] addr_t;

    // Micro-op codes issued one per cycle
    typedef enum logic [3:0] {
        UOP_NOP       = 4'h0,
        // Data latch takes the input byte
        UOP_LATCH     = 4'h1,
        // DL over DB into the accumulator
        UOP_LDA       = 4'h2,
        // Transfers over SB
        UOP_TAX       = 4'h3,
        UOP_TAY       = 4'h4,
        UOP_TXA       = 4'h5,
        UOP_TYA       = 4'h6,
        UOP_TSX       = 4'h7,
        UOP_TXS       = 4'h8,
        // Jump halves from the data latch
        UOP_PCL_LOAD  = 4'h9,
        UOP_PCH_LOAD  = 4'ha,
        // PC out, read, then PC + 1
        UOP_FETCH     = 4'hb,
        // Accumulator written to page one at S
        UOP_PUSH_A    = 4'hc,
        // Vector reads with low address bits pulled down
        UOP_RESET_VEC = 4'hd,
        UOP_NMI_VEC   = 4'he,
        UOP_IRQ_VEC   = 4'hf
    } uop_e;

endpackage

`default_nettype wire

//--- hw/uop_decoder.sv
`default_nettype none

module uop_decoder (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_uop_valid,
    input  cpu_dp_pkg::uop_e  i_uop,
    // Bus source enables
    output logic              o_dl_db,
    output logic              o_dl_adl,
    output logic              o_dl_adh,
    output logic              o_pcl_adl,
    output logic              o_pcl_db,
    output logic              o_pch_adh,
    output logic              o_pch_db,
    output logic              o_x_sb,
    output logic              o_y_sb,
    output logic              o_ac_sb,
    output logic              o_ac_db,
    output logic              o_s_sb,
    output logic              o_s_adl,
    // Open-drain pull-downs
    output logic              o_zero_adl0,
    output logic              o_zero_adl1,
    output logic              o_zero_adl2,
    output logic              o_zero_adh0,
    output logic              o_zero_adh1_7,
    // Register strobes
    output logic              o_dl_load,
    output logic              o_x_load,
    output logic              o_y_load,
    output logic              o_s_load,
    output logic              o_ac_load_sb,
    output logic              o_ac_load_db,
    output logic              o_s_dec,
    // Program counter strobes
    output logic              o_pc_inc,
    output logic              o_pcl_load,
    output logic              o_pch_load,
    // Memory strobes
    output logic              o_rd,
    output logic              o_wr
);

    typedef struct packed {
        logic dl_db;
        logic dl_adl;
        logic dl_adh;
        logic pcl_adl;
        logic pcl_db;
        logic pch_adh;
        logic pch_db;
        logic x_sb;
        logic y_sb;
        logic ac_sb;
        logic ac_db;
        logic s_sb;
        logic s_adl;
        logic zero_adl0;
        logic zero_adl1;
        logic zero_adl2;
        logic zero_adh0;
        logic zero_adh1_7;
        logic dl_load;
        logic x_load;
        logic y_load;
        logic s_load;
        logic ac_load_sb;
        logic ac_load_db;
        logic s_dec;
        logic pc_inc;
        logic pcl_load;
        logic pch_load;
        logic rd;
        logic wr;
    } ctrl_t;

    ctrl_t ctrl_d;
    ctrl_t r_ctrl;

    // Decode the micro-op being accepted this cycle
    always_comb
    begin
        ctrl_d = '0;
        if (i_uop_valid)
        begin
            case (i_uop)
                cpu_dp_pkg::UOP_NOP:      ctrl_d = '0;
                cpu_dp_pkg::UOP_LATCH:    ctrl_d = '{dl_load: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_LDA:
                    ctrl_d = '{dl_db: 1'b1, ac_load_db: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_TAX:      ctrl_d = '{ac_sb: 1'b1, x_load: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_TAY:      ctrl_d = '{ac_sb: 1'b1, y_load: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_TXA:
                    ctrl_d = '{x_sb: 1'b1, ac_load_sb: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_TYA:
                    ctrl_d = '{y_sb: 1'b1, ac_load_sb: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_TSX:      ctrl_d = '{s_sb: 1'b1, x_load: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_TXS:      ctrl_d = '{x_sb: 1'b1, s_load: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_PCL_LOAD:
                    ctrl_d = '{dl_adl: 1'b1, pcl_load: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_PCH_LOAD:
                    ctrl_d = '{dl_adh: 1'b1, pch_load: 1'b1, default: 1'b0};
                cpu_dp_pkg::UOP_FETCH:
                    ctrl_d = '{pcl_adl: 1'b1, pch_adh: 1'b1, rd: 1'b1, pc_inc: 1'b1,
                               default: 1'b0};
                // Stack lives in page one, so ADH reads 0x01
                cpu_dp_pkg::UOP_PUSH_A:
                    ctrl_d = '{s_adl: 1'b1, zero_adh1_7: 1'b1, ac_db: 1'b1, wr: 1'b1,
                               s_dec: 1'b1, default: 1'b0};
                // 0xFFFC
                cpu_dp_pkg::UOP_RESET_VEC:
                    ctrl_d = '{zero_adl0: 1'b1, zero_adl1: 1'b1, rd: 1'b1, default: 1'b0};
                // 0xFFFA
                cpu_dp_pkg::UOP_NMI_VEC:
                    ctrl_d = '{zero_adl0: 1'b1, zero_adl2: 1'b1, rd: 1'b1, default: 1'b0};
                // 0xFFFE
                cpu_dp_pkg::UOP_IRQ_VEC:
                    ctrl_d = '{zero_adl0: 1'b1, rd: 1'b1, default: 1'b0};
                default:                  ctrl_d = '0;
            endcase
        end
    end

    // Held for exactly the execute cycle
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
            r_ctrl <= '0;
        else
            r_ctrl <= ctrl_d;
    end

    // Same order as the fields of ctrl_t
    assign {o_dl_db, o_dl_adl, o_dl_adh, o_pcl_adl, o_pcl_db, o_pch_adh, o_pch_db,
            o_x_sb, o_y_sb, o_ac_sb, o_ac_db, o_s_sb, o_s_adl,
            o_zero_adl0, o_zero_adl1, o_zero_adl2, o_zero_adh0, o_zero_adh1_7,
            o_dl_load, o_x_load, o_y_load, o_s_load, o_ac_load_sb, o_ac_load_db, o_s_dec,
            o_pc_inc, o_pcl_load, o_pch_load, o_rd, o_wr} = r_ctrl;

endmodule

`default_nettype wire

//--- hw/bus_routing.sv
`default_nettype none

`include "cpu_dp_macros.svh"

module bus_routing (
    input  logic              i_clk,
    input  logic              i_arst_n,
    // Data latch
    input  cpu_dp_pkg::byte_t i_dl,
    input  logic              i_dl_db,
    input  logic              i_dl_adl,
    input  logic              i_dl_adh,
    // Program counter halves
    input  cpu_dp_pkg::byte_t i_pcl,
    input  logic              i_pcl_adl,
    input  logic              i_pcl_db,
    input  cpu_dp_pkg::byte_t i_pch,
    input  logic              i_pch_adh,
    input  logic              i_pch_db,
    // Index registers
    input  cpu_dp_pkg::byte_t i_x,
    input  logic              i_x_sb,
    input  cpu_dp_pkg::byte_t i_y,
    input  logic              i_y_sb,
    // Accumulator
    input  cpu_dp_pkg::byte_t i_ac,
    input  logic              i_ac_sb,
    input  logic              i_ac_db,
    // Stack pointer
    input  cpu_dp_pkg::byte_t i_s,
    input  logic              i_s_sb,
    input  logic              i_s_adl,
    // Open-drain pull-downs
    input  logic              i_zero_adl0,
    input  logic              i_zero_adl1,
    input  logic              i_zero_adl2,
    input  logic              i_zero_adh0,
    input  logic              i_zero_adh1_7,
    // Resolved buses
    output cpu_dp_pkg::byte_t o_bus_db,
    output cpu_dp_pkg::byte_t o_bus_sb,
    output cpu_dp_pkg::byte_t o_bus_adl,
    output cpu_dp_pkg::byte_t o_bus_adh
);

    // On DB the later source in this list wins
    always_comb
    begin
        o_bus_db = `CPU_DP_IDLE_BUS;
        if (i_dl_db)
            o_bus_db = i_dl;
        if (i_pcl_db)
            o_bus_db = i_pcl;
        if (i_pch_db)
            o_bus_db = i_pch;
        if (i_ac_db)
            o_bus_db = i_ac;
    end

    // SB
    always_comb
    begin
        o_bus_sb = `CPU_DP_IDLE_BUS;
        if (i_x_sb)
            o_bus_sb = i_x;
        if (i_y_sb)
            o_bus_sb = i_y;
        if (i_ac_sb)
            o_bus_sb = i_ac;
        if (i_s_sb)
            o_bus_sb = i_s;
    end

    // ADL pull-downs act after the sources
    always_comb
    begin
        o_bus_adl = `CPU_DP_IDLE_BUS;
        if (i_dl_adl)
            o_bus_adl = i_dl;
        if (i_pcl_adl)
            o_bus_adl = i_pcl;
        if (i_s_adl)
            o_bus_adl = i_s;
        if (i_zero_adl0)
            o_bus_adl[0] = 1'b0;
        if (i_zero_adl1)
            o_bus_adl[1] = 1'b0;
        if (i_zero_adl2)
            o_bus_adl[2] = 1'b0;
    end

    // Upper seven ADH bits share one pull-down
    always_comb
    begin
        o_bus_adh = `CPU_DP_IDLE_BUS;
        if (i_dl_adh)
            o_bus_adh = i_dl;
        if (i_pch_adh)
            o_bus_adh = i_pch;
        if (i_zero_adh0)
            o_bus_adh[0] = 1'b0;
        if (i_zero_adh1_7)
            o_bus_adh[`CPU_DP_DATA_W-1:1] = '0;
    end

endmodule

`default_nettype wire

//--- hw/register_bank.sv
`default_nettype none

module register_bank (
    input  logic              i_clk,
    input  logic              i_arst_n,
    // Byte from memory and the two data buses
    input  cpu_dp_pkg::byte_t i_data,
    input  cpu_dp_pkg::byte_t i_bus_db,
    input  cpu_dp_pkg::byte_t i_bus_sb,
    // Load strobes
    input  logic              i_dl_load,
    input  logic              i_x_load,
    input  logic              i_y_load,
    input  logic              i_s_load,
    input  logic              i_ac_load_sb,
    input  logic              i_ac_load_db,
    input  logic              i_s_dec,
    // Register values
    output cpu_dp_pkg::byte_t o_dl,
    output cpu_dp_pkg::byte_t o_x,
    output cpu_dp_pkg::byte_t o_y,
    output cpu_dp_pkg::byte_t o_ac,
    output cpu_dp_pkg::byte_t o_s
);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_dl <= '0;
            o_x  <= '0;
            o_y  <= '0;
            o_ac <= '0;
            // Stack starts at the top of page one
            o_s  <= '1;
        end
        else
        begin
            if (i_dl_load)
                o_dl <= i_data;
            if (i_x_load)
                o_x <= i_bus_sb;
            if (i_y_load)
                o_y <= i_bus_sb;

            // Only one accumulator source per micro-op
            if (i_ac_load_sb)
                o_ac <= i_bus_sb;
            else if (i_ac_load_db)
                o_ac <= i_bus_db;

            // Post-decrement after a push wraps at zero
            if (i_s_load)
                o_s <= i_bus_sb;
            else if (i_s_dec)
                o_s <= o_s - 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/program_counter.sv
`default_nettype none

module program_counter (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  cpu_dp_pkg::byte_t i_bus_adl,
    input  cpu_dp_pkg::byte_t i_bus_adh,
    input  logic              i_pcl_load,
    input  logic              i_pch_load,
    input  logic              i_pc_inc,
    output cpu_dp_pkg::byte_t o_pcl,
    output cpu_dp_pkg::byte_t o_pch
);

    cpu_dp_pkg::addr_t pc_next;

    // Full 16-bit increment so the carry ripples into PCH
    assign pc_next = {o_pch, o_pcl} + 1'b1;

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_pcl <= '0;
            o_pch <= '0;
        end
        else if (i_pc_inc)
        begin
            {o_pch, o_pcl} <= pc_next;
        end
        else
        begin
            // Jump target arrives one half at a time
            if (i_pcl_load)
                o_pcl <= i_bus_adl;
            if (i_pch_load)
                o_pch <= i_bus_adh;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpu_datapath.sv
`default_nettype none

module cpu_datapath (
    input  logic              i_clk,
    input  logic              i_arst_n,
    input  logic              i_uop_valid,
    input  cpu_dp_pkg::uop_e  i_uop,
    input  cpu_dp_pkg::byte_t i_data,
    output cpu_dp_pkg::addr_t o_addr,
    output cpu_dp_pkg::byte_t o_data,
    output logic              o_rd,
    output logic              o_wr
);

    // Bus source enables
    logic dl_db, dl_adl, dl_adh;
    logic pcl_adl, pcl_db, pch_adh, pch_db;
    logic x_sb, y_sb, ac_sb, ac_db, s_sb, s_adl;

    // Open-drain pull-downs
    logic zero_adl0, zero_adl1, zero_adl2, zero_adh0, zero_adh1_7;

    // Register and PC strobes
    logic dl_load, x_load, y_load, s_load, ac_load_sb, ac_load_db, s_dec;
    logic pc_inc, pcl_load, pch_load;

    // Buses and register values
    cpu_dp_pkg::byte_t bus_db, bus_sb, bus_adl, bus_adh;
    cpu_dp_pkg::byte_t dl, x, y, ac, s, pcl, pch;

    uop_decoder uop_decoder_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_uop_valid(i_uop_valid), .i_uop(i_uop),
        .o_dl_db(dl_db), .o_dl_adl(dl_adl), .o_dl_adh(dl_adh),
        .o_pcl_adl(pcl_adl), .o_pcl_db(pcl_db), .o_pch_adh(pch_adh), .o_pch_db(pch_db),
        .o_x_sb(x_sb), .o_y_sb(y_sb), .o_ac_sb(ac_sb), .o_ac_db(ac_db),
        .o_s_sb(s_sb), .o_s_adl(s_adl),
        .o_zero_adl0(zero_adl0), .o_zero_adl1(zero_adl1), .o_zero_adl2(zero_adl2),
        .o_zero_adh0(zero_adh0), .o_zero_adh1_7(zero_adh1_7),
        .o_dl_load(dl_load), .o_x_load(x_load), .o_y_load(y_load), .o_s_load(s_load),
        .o_ac_load_sb(ac_load_sb), .o_ac_load_db(ac_load_db), .o_s_dec(s_dec),
        .o_pc_inc(pc_inc), .o_pcl_load(pcl_load), .o_pch_load(pch_load),
        .o_rd(o_rd), .o_wr(o_wr)
    );

    bus_routing bus_routing_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_dl(dl), .i_dl_db(dl_db), .i_dl_adl(dl_adl), .i_dl_adh(dl_adh),
        .i_pcl(pcl), .i_pcl_adl(pcl_adl), .i_pcl_db(pcl_db),
        .i_pch(pch), .i_pch_adh(pch_adh), .i_pch_db(pch_db),
        .i_x(x), .i_x_sb(x_sb), .i_y(y), .i_y_sb(y_sb),
        .i_ac(ac), .i_ac_sb(ac_sb), .i_ac_db(ac_db),
        .i_s(s), .i_s_sb(s_sb), .i_s_adl(s_adl),
        .i_zero_adl0(zero_adl0), .i_zero_adl1(zero_adl1), .i_zero_adl2(zero_adl2),
        .i_zero_adh0(zero_adh0), .i_zero_adh1_7(zero_adh1_7),
        .o_bus_db(bus_db), .o_bus_sb(bus_sb), .o_bus_adl(bus_adl), .o_bus_adh(bus_adh)
    );

    register_bank register_bank_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_data(i_data), .i_bus_db(bus_db), .i_bus_sb(bus_sb),
        .i_dl_load(dl_load), .i_x_load(x_load), .i_y_load(y_load), .i_s_load(s_load),
        .i_ac_load_sb(ac_load_sb), .i_ac_load_db(ac_load_db), .i_s_dec(s_dec),
        .o_dl(dl), .o_x(x), .o_y(y), .o_ac(ac), .o_s(s)
    );

    program_counter program_counter_inst (
        .i_clk(i_clk), .i_arst_n(i_arst_n),
        .i_bus_adl(bus_adl), .i_bus_adh(bus_adh),
        .i_pcl_load(pcl_load), .i_pch_load(pch_load), .i_pc_inc(pc_inc),
        .o_pcl(pcl), .o_pch(pch)
    );

    // Address pins follow the two address buses
    assign o_addr = {bus_adh, bus_adl};
    assign o_data = bus_db;

endmodule

`default_nettype wire

//--- bench/cpu_datapath_chk.sv
`default_nettype none

module cpu_datapath_chk (
    input logic i_clk,
    input logic i_arst_n,
    // DB sources
    input logic i_dl_db,
    input logic i_pcl_db,
    input logic i_pch_db,
    input logic i_ac_db,
    // SB sources
    input logic i_x_sb,
    input logic i_y_sb,
    input logic i_ac_sb,
    input logic i_s_sb,
    // ADL sources
    input logic i_dl_adl,
    input logic i_pcl_adl,
    input logic i_s_adl,
    // ADH sources
    input logic i_dl_adh,
    input logic i_pch_adh,
    // Memory strobes
    input logic i_rd,
    input logic i_wr
);

    timeunit 1ns;
    timeprecision 1ps;

    // Number of assertion failures so far
    int fail_count = 0;

    db_single_src: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_dl_db, i_pcl_db, i_pch_db, i_ac_db}))
        else
        begin
            $error("More than one source drives DB");
            fail_count++;
        end

    sb_single_src: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_x_sb, i_y_sb, i_ac_sb, i_s_sb}))
        else
        begin
            $error("More than one source drives SB");
            fail_count++;
        end

    adl_single_src: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_dl_adl, i_pcl_adl, i_s_adl}))
        else
        begin
            $error("More than one source drives ADL");
            fail_count++;
        end

    adh_single_src: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $onehot0({i_dl_adh, i_pch_adh}))
        else
        begin
            $error("More than one source drives ADH");
            fail_count++;
        end

    // A cycle is either a read or a write
    rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_rd && i_wr))
        else
        begin
            $error("Read and write strobes high together");
            fail_count++;
        end

    quiet_in_reset: assert property (@(posedge i_clk) !i_arst_n |-> !(i_rd || i_wr))
        else
        begin
            $error("Memory strobe high during reset");
            fail_count++;
        end

endmodule

bind cpu_datapath cpu_datapath_chk cpu_datapath_chk_inst (
    .i_clk(i_clk),
    .i_arst_n(i_arst_n),
    .i_dl_db(dl_db), .i_pcl_db(pcl_db), .i_pch_db(pch_db), .i_ac_db(ac_db),
    .i_x_sb(x_sb), .i_y_sb(y_sb), .i_ac_sb(ac_sb), .i_s_sb(s_sb),
    .i_dl_adl(dl_adl), .i_pcl_adl(pcl_adl), .i_s_adl(s_adl),
    .i_dl_adh(dl_adh), .i_pch_adh(pch_adh),
    .i_rd(o_rd),
    .i_wr(o_wr)
);

`default_nettype wire

//--- bench/cpu_datapath_tb.sv
`default_nettype none

module cpu_datapath_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 16;
    localparam int STREAM_LEN = 6;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              uop_valid;
    cpu_dp_pkg::uop_e  uop;
    cpu_dp_pkg::byte_t data_in;
    cpu_dp_pkg::addr_t addr;
    cpu_dp_pkg::byte_t data_out;
    logic              rd;
    logic              wr;

    logic [15:0]       lfsr_state = 16'd52;
    int                err_count = 0;
    int                check_count = 0;
    // Expected stack pointer that starts at the top of page one
    cpu_dp_pkg::byte_t exp_s;

    cpu_datapath cpu_datapath_inst (
        .i_clk(clk),
        .i_arst_n(arst_n),
        .i_uop_valid(uop_valid),
        .i_uop(uop),
        .i_data(data_in),
        .o_addr(addr),
        .o_data(data_out),
        .o_rd(rd),
        .o_wr(wr)
    );

    always #2 clk = ~clk;

    // Galois LFSR stepped once per output bit
    function automatic cpu_dp_pkg::byte_t rand_byte();
        cpu_dp_pkg::byte_t val;
        logic              lsb;
        val = '0;
        for (int i = 0; i < 8; i++)
        begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb)
                lfsr_state = lfsr_state ^ 16'hB400;
            val = {val[6:0], lsb};
        end
        return val;
    endfunction

    task automatic check_byte(input string name, input cpu_dp_pkg::byte_t got,
                              input cpu_dp_pkg::byte_t exp);
        check_count++;
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s: got 0x%02h, expected 0x%02h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic check_addr(input string name, input cpu_dp_pkg::addr_t got,
                              input cpu_dp_pkg::addr_t exp);
        check_count++;
        if (got !== exp)
        begin
            $display("[ERROR] %0t ns %s: got 0x%04h, expected 0x%04h", $time, name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int start_errs);
        if (err_count == start_errs)
            $display("%-10s ok", name);
        else
            $display("%-10s %0d errors", name, err_count - start_errs);
    endtask

    // Returns at the start of the execute cycle
    task automatic issue_uop(input cpu_dp_pkg::uop_e op, input cpu_dp_pkg::byte_t value);
        @(posedge clk);
        uop_valid <= 1'b1;
        uop       <= op;
        data_in   <= value;
        @(posedge clk);
        uop_valid <= 1'b0;
        uop       <= cpu_dp_pkg::UOP_NOP;
    endtask

    task automatic wait_strobe(output logic seen, output int cycles);
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            if (rd || wr)
                seen = 1'b1;
            cycles++;
        end
    endtask

    task automatic mem_op(input string name, input cpu_dp_pkg::uop_e op, input logic exp_wr,
                          input cpu_dp_pkg::addr_t exp_addr, input cpu_dp_pkg::byte_t exp_data);
        logic seen;
        int   cycles;
        issue_uop(op, 8'h00);
        wait_strobe(seen, cycles);
        if (!seen)
        begin
            $display("%s: no memory strobe within %0d cycles", name, WAIT_LIMIT);
            err_count++;
        end
        else
        begin
            // The strobe belongs in the execute cycle itself
            if (cycles != 1)
            begin
                $display("%s: memory strobe came %0d cycles late", name, cycles - 1);
                err_count++;
            end
            if (wr !== exp_wr || rd !== !exp_wr)
            begin
                $display("%s: strobe direction wrong, write expected %0b", name, exp_wr);
                err_count++;
            end
            check_addr({name, " o_addr"}, addr, exp_addr);
            if (exp_wr)
                check_byte({name, " o_data"}, data_out, exp_data);
            // Strobe lasts one cycle only
            @(negedge clk);
            if (rd || wr)
            begin
                $display("%s: memory strobe held for more than one cycle", name);
                err_count++;
            end
        end
    endtask

    task automatic load_ac(input cpu_dp_pkg::byte_t value);
        issue_uop(cpu_dp_pkg::UOP_LATCH, value);
        issue_uop(cpu_dp_pkg::UOP_LDA, 8'h00);
    endtask

    task automatic load_pc(input cpu_dp_pkg::addr_t target);
        issue_uop(cpu_dp_pkg::UOP_LATCH, target[7:0]);
        issue_uop(cpu_dp_pkg::UOP_PCL_LOAD, 8'h00);
        issue_uop(cpu_dp_pkg::UOP_LATCH, target[15:8]);
        issue_uop(cpu_dp_pkg::UOP_PCH_LOAD, 8'h00);
    endtask

    task automatic push_expect(input string name, input cpu_dp_pkg::byte_t value);
        mem_op(name, cpu_dp_pkg::UOP_PUSH_A, 1'b1, {8'h01, exp_s}, value);
        exp_s = exp_s - 8'd1;
    endtask

    task automatic test_vectors();
        int start;
        start = err_count;
        repeat (4)
        begin
            @(negedge clk);
            if (rd || wr)
            begin
                $display("vectors: memory strobe active while idle after reset");
                err_count++;
            end
        end
        mem_op("RESET_VEC", cpu_dp_pkg::UOP_RESET_VEC, 1'b0, 16'hFFFC, 8'h00);
        mem_op("NMI_VEC", cpu_dp_pkg::UOP_NMI_VEC, 1'b0, 16'hFFFA, 8'h00);
        mem_op("IRQ_VEC", cpu_dp_pkg::UOP_IRQ_VEC, 1'b0, 16'hFFFE, 8'h00);
        report_test("vectors", start);
    endtask

    task automatic test_jump();
        int start;
        start = err_count;
        load_pc(16'h1234);
        mem_op("FETCH", cpu_dp_pkg::UOP_FETCH, 1'b0, 16'h1234, 8'h00);
        mem_op("FETCH", cpu_dp_pkg::UOP_FETCH, 1'b0, 16'h1235, 8'h00);
        // Carry out of PCL
        load_pc(16'h12FF);
        mem_op("FETCH", cpu_dp_pkg::UOP_FETCH, 1'b0, 16'h12FF, 8'h00);
        mem_op("FETCH", cpu_dp_pkg::UOP_FETCH, 1'b0, 16'h1300, 8'h00);
        report_test("jump", start);
    endtask

    task automatic test_push();
        cpu_dp_pkg::byte_t v;
        int                start;
        start = err_count;
        v = rand_byte();
        load_ac(v);
        push_expect("PUSH_A", v);
        push_expect("PUSH_A", v);
        report_test("push", start);
    endtask

    task automatic test_transfers();
        cpu_dp_pkg::byte_t a;
        cpu_dp_pkg::byte_t b;
        cpu_dp_pkg::byte_t t;
        int                start;
        start = err_count;
        a = rand_byte();
        b = rand_byte();
        if (b == a)
            b = ~a;
        load_ac(a);
        issue_uop(cpu_dp_pkg::UOP_TAX, 8'h00);
        issue_uop(cpu_dp_pkg::UOP_TAY, 8'h00);
        load_ac(b);
        issue_uop(cpu_dp_pkg::UOP_TXA, 8'h00);
        push_expect("TXA", a);
        load_ac(b);
        issue_uop(cpu_dp_pkg::UOP_TYA, 8'h00);
        push_expect("TYA", a);
        // X takes the current stack pointer
        t = exp_s;
        issue_uop(cpu_dp_pkg::UOP_TSX, 8'h00);
        load_ac(b);
        issue_uop(cpu_dp_pkg::UOP_TXA, 8'h00);
        push_expect("TSX", t);
        // New stack pointer shows up on the push address
        t = rand_byte();
        load_ac(t);
        issue_uop(cpu_dp_pkg::UOP_TAX, 8'h00);
        issue_uop(cpu_dp_pkg::UOP_TXS, 8'h00);
        exp_s = t;
        push_expect("TXS", t);
        report_test("transfers", start);
    endtask

    task automatic test_stream();
        cpu_dp_pkg::byte_t vals[$];
        int                start;
        int                idx;
        int                got;
        int                cycles;
        start = err_count;
        for (int i = 0; i < STREAM_LEN; i++)
            vals.push_back(rand_byte());
        idx = 0;
        got = 0;
        cycles = 0;
        while (got < STREAM_LEN && cycles < 3 * STREAM_LEN + WAIT_LIMIT)
        begin
            @(posedge clk);
            if (idx < 3 * STREAM_LEN)
            begin
                uop_valid <= 1'b1;
                if (idx % 3 == 0)
                begin
                    uop     <= cpu_dp_pkg::UOP_LATCH;
                    data_in <= vals[idx / 3];
                end
                else if (idx % 3 == 1)
                    uop <= cpu_dp_pkg::UOP_LDA;
                else
                    uop <= cpu_dp_pkg::UOP_PUSH_A;
                idx++;
            end
            else
            begin
                uop_valid <= 1'b0;
                uop       <= cpu_dp_pkg::UOP_NOP;
            end
            @(negedge clk);
            if (wr)
            begin
                check_addr("stream o_addr", addr, {8'h01, exp_s});
                check_byte("stream o_data", data_out, vals[got]);
                exp_s = exp_s - 8'd1;
                got++;
            end
            cycles++;
        end
        if (got < STREAM_LEN)
        begin
            $display("stream: only %0d of %0d writes seen before timeout", got, STREAM_LEN);
            err_count++;
        end
        report_test("stream", start);
    endtask

    initial
    begin
        arst_n    = 1'b0;
        uop_valid = 1'b0;
        uop       = cpu_dp_pkg::UOP_NOP;
        data_in   = '0;
        exp_s     = 8'hFF;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        test_vectors();
        test_jump();
        test_push();
        test_transfers();
        test_stream();

        err_count += cpu_datapath_inst.cpu_datapath_chk_inst.fail_count;
        $display("Checks run: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+hw
hw/cpu_dp_pkg.sv
hw/uop_decoder.sv
hw/bus_routing.sv
hw/register_bank.sv
hw/program_counter.sv
hw/cpu_datapath.sv
bench/cpu_datapath_chk.sv
bench/cpu_datapath_tb.sv

//--- Bender.yml
package:
  name: cpu_datapath

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_dp_pkg.sv
      - hw/uop_decoder.sv
      - hw/bus_routing.sv
      - hw/register_bank.sv
      - hw/program_counter.sv
      - hw/cpu_datapath.sv
  - target: test
    files:
      - bench/cpu_datapath_chk.sv
      - bench/cpu_datapath_tb.sv
